//--- build.f
logic/mem_pkg.sv
logic/ex_stage_if.sv
logic/sram_if.sv
logic/mem_stage_if.sv
logic/memory_access.sv
logic/data_ram.sv
logic/mem_wb_reg.sv
logic/mem_top.sv
tb/mem_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module mem_tb -o mem_tb_sim
output=$(./obj_dir/mem_tb_sim 2>&1 || true)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
fi
exit 1

//--- tb/mem_tb.sv
`timescale 1ns/100ps

module mem_tb;

    typedef struct packed {
        logic [31:0]       cycle;       // edge at which the instruction was driven
        mem_pkg::word_t    pc;
        mem_pkg::word_t    inst;
        logic              rw_en;
        mem_pkg::reg_idx_t rw_addr;
        mem_pkg::word_t    rw_data;
        logic              data_known;  // misaligned loads leave data undefined
        logic              ale;
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    mem_pkg::word_t    in_pc;
    mem_pkg::word_t    in_inst;
    mem_pkg::lsu_op_e  in_lsu_op;
    mem_pkg::word_t    in_ex_result;
    mem_pkg::word_t    in_lsu_data;
    logic              in_rw_en;
    mem_pkg::reg_idx_t in_rw_addr;
    logic              wb_valid;
    mem_pkg::word_t    wb_pc;
    mem_pkg::word_t    wb_inst;
    logic              wb_rw_en;
    mem_pkg::reg_idx_t wb_rw_addr;
    mem_pkg::word_t    wb_rw_data;
    logic              wb_ale;

    logic [7:0]  model_mem [256];  // byte addressed, 64 words
    expect_t     exp_q [$];
    logic [31:0] cycle_cnt = 32'd0;
    logic [31:0] lfsr = 32'd96342;
    logic [5:0]  last_word = 6'd0;

    mem_top DUT (.*);

    // Galois LFSR, one step per bit taken
    function automatic mem_pkg::word_t random_bits(input int n);
        mem_pkg::word_t r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hD000_0001 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic mem_pkg::lsu_op_e pick_op(input logic [3:0] sel);
        case (sel)
            4'd0, 4'd1:   return mem_pkg::st_b;
            4'd2, 4'd3:   return mem_pkg::st_h;
            4'd4, 4'd5:   return mem_pkg::st_w;
            4'd6:         return mem_pkg::ld_b;
            4'd7:         return mem_pkg::ld_bu;
            4'd8:         return mem_pkg::ld_h;
            4'd9:         return mem_pkg::ld_hu;
            4'd10, 4'd11: return mem_pkg::ld_w;
            default:      return mem_pkg::op_none;
        endcase
    endfunction

    function automatic int access_size(input mem_pkg::lsu_op_e op);
        case (op)
            mem_pkg::ld_b, mem_pkg::ld_bu, mem_pkg::st_b: return 1;
            mem_pkg::ld_h, mem_pkg::ld_hu, mem_pkg::st_h: return 2;
            mem_pkg::ld_w, mem_pkg::st_w:                 return 4;
            default:                                      return 0;
        endcase
    endfunction

    // Mostly aligned, often the same word as the access before
    function automatic mem_pkg::word_t make_addr(input int size);
        mem_pkg::word_t a;
        mem_pkg::word_t r;
        a = random_bits(32);
        r = random_bits(3);
        if (r[0]) a[7:2] = last_word;
        if (r[2:1] != 2'b00 && size == 2) a[0] = 1'b0;
        if (r[2:1] != 2'b00 && size == 4) a[1:0] = 2'b00;
        last_word = a[7:2];
        return a;
    endfunction

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mem_pkg::word_t got,
                              input mem_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_idx(input string name, input mem_pkg::reg_idx_t got,
                             input mem_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Driven at edge E, sampled by the DUT at E+1, seen at the wb ports at E+3
    task automatic next_edge();
        expect_t e;
        @(posedge clk);
        cycle_cnt = cycle_cnt + 32'd1;
        if (exp_q.size() != 0 && exp_q[0].cycle + 32'd3 == cycle_cnt) begin
            e = exp_q.pop_front();
            check_flag("wb_valid", wb_valid, 1'b1);
            check_word("wb_pc", wb_pc, e.pc);
            check_word("wb_inst", wb_inst, e.inst);
            check_flag("wb_rw_en", wb_rw_en, e.rw_en);
            check_idx("wb_rw_addr", wb_rw_addr, e.rw_addr);
            check_flag("wb_ale", wb_ale, e.ale);
            if (e.data_known) check_word("wb_rw_data", wb_rw_data, e.rw_data);
        end else begin
            check_flag("wb_valid", wb_valid, 1'b0);
            check_flag("wb_rw_en", wb_rw_en, 1'b0);
        end
    endtask

    task automatic issue(input mem_pkg::lsu_op_e op, input mem_pkg::word_t addr,
                         input mem_pkg::word_t data);
        expect_t        e;
        mem_pkg::word_t r;
        logic [7:0]     a;
        logic [15:0]    half;
        int             size;
        logic           mis;
        logic           is_load;
        logic           rw_en;
        a       = addr[7:0];
        size    = access_size(op);
        mis     = size > 1 && (int'(a[1:0]) % size) != 0;
        is_load = op inside {mem_pkg::ld_b, mem_pkg::ld_bu, mem_pkg::ld_h,
                             mem_pkg::ld_hu, mem_pkg::ld_w};
        half    = {model_mem[a + 8'd1], model_mem[a]};
        r       = random_bits(32);
        e.cycle = cycle_cnt;
        e.pc    = {r[31:2], 2'b00};
        e.inst  = random_bits(32);
        r       = random_bits(6);
        rw_en   = is_load ? 1'b1 : r[5];
        e.rw_addr    = r[4:0];
        e.rw_en      = rw_en && !mis;
        e.ale        = mis;
        e.data_known = !(is_load && mis);
        e.rw_data    = addr;  // ALU result unless an aligned load
        if (!mis) begin
            case (op)
                mem_pkg::st_b: model_mem[a] = data[7:0];
                mem_pkg::st_h: begin
                    model_mem[a]        = data[7:0];
                    model_mem[a + 8'd1] = data[15:8];
                end
                mem_pkg::st_w: begin
                    for (int k = 0; k < 4; k++) begin
                        model_mem[a + 8'(k)] = data[8*k +: 8];
                    end
                end
                mem_pkg::ld_b:  e.rw_data = {{24{model_mem[a][7]}}, model_mem[a]};
                mem_pkg::ld_bu: e.rw_data = {24'h000000, model_mem[a]};
                mem_pkg::ld_h:  e.rw_data = {{16{half[15]}}, half};
                mem_pkg::ld_hu: e.rw_data = {16'h0000, half};
                mem_pkg::ld_w:  e.rw_data = {model_mem[a + 8'd3], model_mem[a + 8'd2], half};
                default: ;
            endcase
        end
        in_valid     <= 1'b1;
        in_pc        <= e.pc;
        in_inst      <= e.inst;
        in_lsu_op    <= op;
        in_ex_result <= addr;
        in_lsu_data  <= data;
        in_rw_en     <= rw_en;
        in_rw_addr   <= e.rw_addr;
        exp_q.push_back(e);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

    initial begin
        mem_pkg::lsu_op_e op;
        mem_pkg::word_t   r;
        int               waited;
        in_valid     <= 1'b0;
        in_pc        <= '0;
        in_inst      <= '0;
        in_lsu_op    <= mem_pkg::op_none;
        in_ex_result <= '0;
        in_lsu_data  <= '0;
        in_rw_en     <= 1'b0;
        in_rw_addr   <= '0;
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > 20) begin
                $display("Reset was never released");
                stop_with_failure();
            end
        end
        // Fill every word so later loads read known data
        for (int w = 0; w < 64; w++) begin
            next_edge();
            r = random_bits(32);
            issue(mem_pkg::st_w, {r[31:8], 6'(w), 2'b00}, random_bits(32));
        end
        for (int n = 0; n < 2000; n++) begin
            next_edge();
            r  = random_bits(7);
            op = pick_op(r[3:0]);
            if (r[6:4] == 3'b000) begin
                in_valid     <= 1'b0;  // bubble with a junk payload
                in_lsu_op    <= op;
                in_ex_result <= make_addr(access_size(op));
                in_lsu_data  <= random_bits(32);
            end else begin
                issue(op, make_addr(access_size(op)), random_bits(32));
            end
        end
        waited = 0;
        while (exp_q.size() != 0) begin
            next_edge();
            in_valid <= 1'b0;
            waited++;
            if (waited > 10) begin
                $display("Pipeline did not deliver the last results in time");
                stop_with_failure();
            end
        end
        repeat (3) next_edge();  // nothing valid may trail the last result
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- logic/mem_top.sv
`timescale 1ns/100ps

module mem_top #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  mem_pkg::word_t    in_pc,
    input  mem_pkg::word_t    in_inst,
    input  mem_pkg::lsu_op_e  in_lsu_op,
    input  mem_pkg::word_t    in_ex_result,
    input  mem_pkg::word_t    in_lsu_data,
    input  logic              in_rw_en,
    input  mem_pkg::reg_idx_t in_rw_addr,
    output logic              wb_valid,
    output mem_pkg::word_t    wb_pc,
    output mem_pkg::word_t    wb_inst,
    output logic              wb_rw_en,
    output mem_pkg::reg_idx_t wb_rw_addr,
    output mem_pkg::word_t    wb_rw_data,
    output logic              wb_ale
);

    sram_if #(.ADDR_WIDTH(ADDR_WIDTH)) sram_bus ();
    mem_stage_if mem_info ();

    memory_access #(.ADDR_WIDTH(ADDR_WIDTH)) u_access (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_pc        (in_pc),
        .in_inst      (in_inst),
        .in_lsu_op    (in_lsu_op),
        .in_ex_result (in_ex_result),
        .in_lsu_data  (in_lsu_data),
        .in_rw_en     (in_rw_en),
        .in_rw_addr   (in_rw_addr),
        .sram         (sram_bus.m),
        .mem_info     (mem_info.o)
    );

    data_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
        .clk  (clk),
        .sram (sram_bus.s)
    );

    mem_wb_reg u_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_info   (mem_info.i),
        .sram       (sram_bus.r),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .wb_inst    (wb_inst),
        .wb_rw_en   (wb_rw_en),
        .wb_rw_addr (wb_rw_addr),
        .wb_rw_data (wb_rw_data),
        .wb_ale     (wb_ale)
    );

endmodule

//--- logic/mem_wb_reg.sv
`timescale 1ns/100ps

module mem_wb_reg (
    input  logic              clk,
    input  logic              rst_n,
    mem_stage_if.i            mem_info,
    sram_if.r                 sram,
    output logic              wb_valid,
    output mem_pkg::word_t    wb_pc,
    output mem_pkg::word_t    wb_inst,
    output logic              wb_rw_en,
    output mem_pkg::reg_idx_t wb_rw_addr,
    output mem_pkg::word_t    wb_rw_data,
    output logic              wb_ale
);

    logic             rw_en_q;
    logic             ale_q;
    mem_pkg::lsu_op_e lsu_op_q;
    logic [1:0]       byte_off_q;
    mem_pkg::word_t   alu_result_q;
    logic [7:0]       byte_sel;
    logic [15:0]      half_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            rw_en_q  <= 1'b0;
            ale_q    <= 1'b0;
        end else begin
            wb_valid <= mem_info.valid;
            rw_en_q  <= mem_info.rw_en;
            ale_q    <= mem_info.ale;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc        <= mem_info.pc;
        wb_inst      <= mem_info.inst;
        wb_rw_addr   <= mem_info.rw_addr;
        lsu_op_q     <= mem_info.lsu_op;
        byte_off_q   <= mem_info.byte_off;
        alu_result_q <= mem_info.alu_result;
    end

    // Little-endian lane pick from the read word
    assign byte_sel = sram.rdata[{byte_off_q, 3'b000} +: 8];
    assign half_sel = sram.rdata[{byte_off_q[1], 4'b0000} +: 16];

    always_comb begin
        case (lsu_op_q)
            mem_pkg::ld_b:  wb_rw_data = {{24{byte_sel[7]}}, byte_sel};
            mem_pkg::ld_bu: wb_rw_data = {24'h000000, byte_sel};
            mem_pkg::ld_h:  wb_rw_data = {{16{half_sel[15]}}, half_sel};
            mem_pkg::ld_hu: wb_rw_data = {16'h0000, half_sel};
            mem_pkg::ld_w:  wb_rw_data = sram.rdata;
            default:        wb_rw_data = alu_result_q;  // stores and ALU ops
        endcase
    end

    assign wb_rw_en = rw_en_q && !ale_q;
    assign wb_ale   = ale_q;

    // Misaligned flag only for a live access off its boundary
    a_ale_has_offset: assert property (
        @(posedge clk) disable iff (!rst_n)
            mem_info.ale |-> (mem_info.valid && mem_info.byte_off != 2'b00)
    );

endmodule

//--- logic/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
    parameter int ADDR_WIDTH = 6
) (
    input logic clk,
    sram_if.s   sram
);

    mem_pkg::word_t mem [2**ADDR_WIDTH];
    mem_pkg::word_t merged;

    // Stored word with the enabled bytes replaced
    always_comb begin
        merged = mem[sram.addr];
        for (int b = 0; b < 4; b++) begin
            if (sram.we && sram.be[b]) begin
                merged[8*b +: 8] = sram.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sram.en) begin
            if (sram.we) begin
                mem[sram.addr] <= merged;
            end
            sram.rdata <= merged;  // write-first read
        end
    end

    // A write strobe from the access unit always carries at least one lane
    a_we_has_be: assert property (
        @(posedge clk) (sram.en && sram.we) |-> (sram.be != 4'b0000)
    );

endmodule

//--- logic/memory_access.sv
`timescale 1ns/100ps

module memory_access #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  mem_pkg::word_t    in_pc,
    input  mem_pkg::word_t    in_inst,
    input  mem_pkg::lsu_op_e  in_lsu_op,
    input  mem_pkg::word_t    in_ex_result,
    input  mem_pkg::word_t    in_lsu_data,
    input  logic              in_rw_en,
    input  mem_pkg::reg_idx_t in_rw_addr,
    sram_if.m                 sram,
    mem_stage_if.o            mem_info
);

    ex_stage_if ex_info ();

    logic [1:0] off;
    logic       is_load;
    logic       is_store;
    logic       misaligned;
    logic [3:0] lane_be;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_info.valid <= 1'b0;
        end else begin
            ex_info.valid <= in_valid;
        end
    end

    // Payload of the execute bundle
    always_ff @(posedge clk) begin
        ex_info.pc        <= in_pc;
        ex_info.inst      <= in_inst;
        ex_info.lsu_op    <= in_lsu_op;
        ex_info.ex_result <= in_ex_result;
        ex_info.lsu_data  <= in_lsu_data;
        ex_info.rw_en     <= in_rw_en;
        ex_info.rw_addr   <= in_rw_addr;
    end

    assign off = ex_info.ex_result[1:0];

    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        misaligned = 1'b0;
        lane_be    = 4'b0000;
        case (ex_info.lsu_op)
            mem_pkg::ld_b, mem_pkg::ld_bu: begin
                is_load = 1'b1;
            end
            mem_pkg::ld_h, mem_pkg::ld_hu: begin
                is_load    = 1'b1;
                misaligned = off[0];
            end
            mem_pkg::ld_w: begin
                is_load    = 1'b1;
                misaligned = |off;
            end
            mem_pkg::st_b: begin
                is_store = 1'b1;
                lane_be  = 4'b0001 << off;
            end
            mem_pkg::st_h: begin
                is_store   = 1'b1;
                misaligned = off[0];
                lane_be    = 4'b0011 << off;
            end
            mem_pkg::st_w: begin
                is_store   = 1'b1;
                misaligned = |off;
                lane_be    = 4'b1111;
            end
            default: ;  // op_none and unused codes
        endcase
    end

    assign sram.en    = ex_info.valid && (is_load || is_store) && !misaligned;
    assign sram.we    = sram.en && is_store;
    assign sram.addr  = ex_info.ex_result[ADDR_WIDTH+1:2];  // upper bits wrap
    assign sram.wdata = ex_info.lsu_data << {off, 3'b000};  // move to byte lane
    assign sram.be    = lane_be;

    assign mem_info.valid      = ex_info.valid;
    assign mem_info.pc         = ex_info.pc;
    assign mem_info.inst       = ex_info.inst;
    assign mem_info.lsu_op     = ex_info.lsu_op;
    assign mem_info.byte_off   = off;
    assign mem_info.alu_result = ex_info.ex_result;
    assign mem_info.rw_en      = ex_info.valid && ex_info.rw_en;
    assign mem_info.rw_addr    = ex_info.rw_addr;
    assign mem_info.ale        = ex_info.valid && misaligned;

    // Execute issues only defined opcodes
    a_defined_op: assert property (
        @(posedge clk) disable iff (!rst_n)
            in_valid |-> in_lsu_op inside {mem_pkg::ld_b, mem_pkg::ld_h, mem_pkg::ld_w,
                                           mem_pkg::st_b, mem_pkg::st_h, mem_pkg::st_w,
                                           mem_pkg::ld_bu, mem_pkg::ld_hu,
                                           mem_pkg::op_none}
    );

endmodule

//--- logic/mem_stage_if.sv
`timescale 1ns/100ps

interface mem_stage_if;

    logic              valid;
    mem_pkg::word_t    pc;
    mem_pkg::word_t    inst;
    mem_pkg::lsu_op_e  lsu_op;
    logic [1:0]        byte_off;    // low address bits for lane select
    mem_pkg::word_t    alu_result;
    logic              rw_en;
    mem_pkg::reg_idx_t rw_addr;
    logic              ale;         // misaligned access

    modport o (
        output valid, pc, inst, lsu_op, byte_off, alu_result, rw_en, rw_addr, ale
    );

    modport i (
        input valid, pc, inst, lsu_op, byte_off, alu_result, rw_en, rw_addr, ale
    );

endinterface

//--- logic/sram_if.sv
`timescale 1ns/100ps

interface sram_if #(
    parameter int ADDR_WIDTH = 6
);

    logic                  en;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;   // word index
    mem_pkg::word_t        wdata;
    logic [3:0]            be;
    mem_pkg::word_t        rdata;

    modport m (
        output en, we, addr, wdata, be
    );

    modport s (
        input  en, we, addr, wdata, be,
        output rdata
    );

    modport r (
        input rdata
    );

endinterface

//--- logic/ex_stage_if.sv
`timescale 1ns/100ps

interface ex_stage_if;

    logic              valid;
    mem_pkg::word_t    pc;
    mem_pkg::word_t    inst;
    mem_pkg::lsu_op_e  lsu_op;
    mem_pkg::word_t    ex_result;  // address for loads and stores
    mem_pkg::word_t    lsu_data;
    logic              rw_en;
    mem_pkg::reg_idx_t rw_addr;

    modport o (
        output valid, pc, inst, lsu_op, ex_result, lsu_data, rw_en, rw_addr
    );

    modport i (
        input valid, pc, inst, lsu_op, ex_result, lsu_data, rw_en, rw_addr
    );

endinterface

//--- logic/mem_pkg.sv
package mem_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Destination register index
    typedef logic [4:0] reg_idx_t;

    // Load/store opcode as decoded by execute
    typedef enum logic [3:0] {
        ld_b    = 4'b0000,
        ld_h    = 4'b0001,
        ld_w    = 4'b0010,
        st_b    = 4'b0100,
        st_h    = 4'b0101,
        st_w    = 4'b0110,
        ld_bu   = 4'b1000,
        ld_hu   = 4'b1001,
        op_none = 4'b1111   // no memory access
    } lsu_op_e;

endpackage
